//--- sparcPipe.f
src/sparcPkg.sv
src/sparcAlu.sv
src/instQueue.sv
src/decodeStage.sv
src/executeStage.sv
src/sparcPipe.sv
verif/tbClock.sv
verif/sparcPipeTb.sv

//--- Makefile
TOP = sparcPipeTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f sparcPipe.f
	./obj_dir/V$(TOP) | tee sim.log
	! grep -q ">>> FAIL" sim.log
	grep -q ">>> PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sparcPipe.f

clean:
	rm -rf obj_dir sim.log

//--- verif/sparcPipeTb.sv
// Self-checking testbench for sparcPipe; random SPARC stream with credit flow on both ends
`timescale 1ns/1ps
`default_nettype none

module sparcPipeTb;

    localparam int NumInst       = 300;
    localparam int TimeoutCycles = 4000;              // 300 credit returns at under 5 cycles each
    localparam logic [3:0] ArithLow [10] = '{4'h0, 4'h8, 4'h4, 4'hC, 4'h1,
                                             4'h5, 4'h2, 4'h6, 4'h3, 4'h7};
    localparam logic [5:0] MemOps [12] = '{6'b000000, 6'b000001, 6'b000010, 6'b000011,
                                           6'b001001, 6'b001010, 6'b001101, 6'b001111,
                                           6'b000100, 6'b000101, 6'b000110, 6'b000111};

    logic                Clk;
    logic                rstN;
    logic                instValid;
    sparcPkg::instWord_t instIn;
    sparcPkg::dataWord_t operandA;
    sparcPkg::dataWord_t operandB;
    logic                resCredit;
    logic                instCredit;
    logic                resValid;
    sparcPkg::result_t   resOut;

    sparcPkg::result_t   expRes [NumInst];            // Expected results in issue order
    sparcPkg::iccFlags_t iccModel;
    int                  seed        = 32'h5b4dbc91;
    int                  sentCnt;
    int                  retCnt;                      // Output credits handed back
    int                  gap;
    int                  gotCnt      = 0;
    int                  creditsBack = 0;             // instCredit pulses seen
    int                  outCredits  = int'(sparcPkg::OutCredits);
    int                  errCount    = 0;

    tbClock u_clock (.Clk, .rstN);

    sparcPipe i_dut (
        .Clk, .rstN, .instValid, .instIn, .operandA, .operandB, .resCredit,
        .instCredit, .resValid, .resOut
    );

    function automatic sparcPkg::memCtrl_t memRule(logic [5:0] op3);
        sparcPkg::memCtrl_t m;
        m.isMem   = 1'b1;
        m.isStore = (op3[5:2] == 4'b0001);
        case (op3[1:0])
            2'b01:   m.size = sparcPkg::SizeByte;
            2'b10:   m.size = sparcPkg::SizeHalf;
            default: m.size = sparcPkg::SizeWord;     // Word, doubleword, swap
        endcase
        m.signExt = (op3 == 6'b001001) || (op3 == 6'b001010);   // ldsb, ldsh
        return m;
    endfunction

    // SPARC result and icc rules; addx and subx take the stored carry
    function automatic sparcPkg::result_t modelExec(sparcPkg::instWord_t inst,
            sparcPkg::dataWord_t a, sparcPkg::dataWord_t b, sparcPkg::iccFlags_t iccIn);
        sparcPkg::result_t   r;
        sparcPkg::dataWord_t bx;
        logic [5:0]          op3;
        logic [32:0]         full;
        logic                v;
        op3  = inst[24:19];
        r    = '{data: '0, icc: iccIn, memCtrl: '0};
        v    = 1'b0;
        bx   = op3[2] ? ~b : b;                       // andn, orn, xnor
        full = '0;
        if (inst[31:30] == sparcPkg::OpMem) begin
            full      = {1'b0, a + b};                // Address only
            r.memCtrl = memRule(op3);
        end else if (inst[31:30] == 2'b00) begin
            full = {1'b0, b};
        end else if (op3[5]) begin
            case (op3[1:0])
                2'b01:   full = {1'b0, a << b[4:0]};
                2'b10:   full = {1'b0, a >> b[4:0]};
                default: full = {1'b0, $signed(a) >>> b[4:0]};
            endcase
        end else if (op3[1:0] == 2'b00 && op3[2]) begin
            full = {1'b0, a} - {1'b0, b} - 33'(op3[3] & iccIn.c);
            v    = (a[31] != b[31]) && (full[31] != a[31]);
        end else if (op3[1:0] == 2'b00) begin
            full = {1'b0, a} + {1'b0, b} + 33'(op3[3] & iccIn.c);
            v    = (a[31] == b[31]) && (full[31] != a[31]);
        end else begin
            case (op3[1:0])
                2'b01:   full = {1'b0, a & bx};
                2'b10:   full = {1'b0, a | bx};
                default: full = {1'b0, a ^ bx};
            endcase
        end
        r.data = full[31:0];
        if (inst[31:30] == sparcPkg::OpArith && op3[5:4] == 2'b01) begin
            r.icc = '{n: full[31], z: (full[31:0] == 32'd0), v: v, c: full[32]};
        end
        return r;
    endfunction

    task automatic sendInst();
        sparcPkg::instWord_t inst;
        sparcPkg::dataWord_t a;
        sparcPkg::dataWord_t b;
        int                  kind;
        inst = $random(seed);
        a    = $random(seed);
        b    = $random(seed);
        kind = $random(seed) & 7;
        if (kind < 5) begin
            inst[31:30] = sparcPkg::OpArith;
            inst[24:19] = {1'b0, inst[0], ArithLow[$unsigned($random(seed)) % 10]};
            if (inst[2:1] == 2'b00) b = a;            // Equal operands reach zero and borrow cases
        end else if (kind == 5) begin
            inst[31:30] = sparcPkg::OpArith;
            inst[24:19] = {4'b1001, (inst[1:0] == 2'b00) ? 2'b11 : inst[1:0]};
        end else if (kind == 6) begin
            inst[31:30] = sparcPkg::OpMem;
            inst[24:19] = MemOps[$unsigned($random(seed)) % 12];
        end else begin
            inst[31:30] = 2'b00;
            inst[24:22] = sparcPkg::OpSethi2;
            b           = {inst[21:0], 10'd0};        // imm22 << 10
        end
        expRes[sentCnt] = modelExec(inst, a, b, iccModel);
        iccModel        = expRes[sentCnt].icc;
        instValid       = 1'b1;
        instIn          = inst;
        operandA        = a;
        operandB        = b;
        sentCnt++;
    endtask

    function automatic int pickGap();
        if (($random(seed) & 15) == 0) begin
            return 20 + ($random(seed) & 31);         // Credit drought
        end
        return $random(seed) & 3;
    endfunction

    function automatic logic allDone();
        return gotCnt == NumInst && retCnt == NumInst;
    endfunction

    initial begin : driveInputs
        int avail;
        instValid = 1'b0;
        instIn    = '0;
        operandA  = '0;
        operandB  = '0;
        resCredit = 1'b0;
        iccModel  = '0;
        sentCnt   = 0;
        retCnt    = 0;
        gap       = 0;
        @(negedge rstN);
        @(posedge rstN);                              // Start after reset release
        forever begin
            @(negedge Clk);
            instValid = 1'b0;
            resCredit = 1'b0;
            avail = sparcPkg::QueueDepth - (sentCnt - creditsBack);
            if (sentCnt < NumInst && avail > 0 && ($random(seed) & 3) != 0) begin
                sendInst();
            end
            if (gap > 0) begin
                gap--;
            end else if (gotCnt > retCnt) begin
                resCredit = 1'b1;
                retCnt++;
                gap = pickGap();
            end
        end
    end

    always @(posedge Clk) begin : countEvents
        gotCnt      <= gotCnt + int'(resValid);
        creditsBack <= creditsBack + int'(instCredit);
        outCredits  <= outCredits - int'(resValid) + int'(resCredit);
    end

    // Data, icc and memCtrl against the model, in issue order
    resultCheck: assert property (@(posedge Clk) disable iff (!rstN)
        resValid |-> resOut == expRes[gotCnt])
        else begin
            errCount++;
            $display("FAILED at %0t: result %0d is %h, expected %h", $time,
                     $sampled(gotCnt), $sampled(resOut), expRes[$sampled(gotCnt)]);
        end

    resultCredit: assert property (@(posedge Clk) disable iff (!rstN)
        resValid |-> outCredits > 0 && gotCnt < NumInst)
        else begin
            errCount++;
            $display("Result at %0t came without an output credit or after the last one", $time);
        end

    inputCredit: assert property (@(posedge Clk) disable iff (!rstN)
        instCredit |-> creditsBack < sentCnt)
        else begin
            errCount++;
            $display("Input credit at %0t returned more credits than instructions sent", $time);
        end

    resetQuiet: assert property (@(posedge Clk) !rstN |-> !resValid && !instCredit)
        else begin
            errCount++;
            $display("Output pulse seen during reset at %0t", $time);
        end

    initial begin : supervise
        int cycles;
        cycles = 0;
        while (!allDone() && cycles < TimeoutCycles) begin
            @(posedge Clk);
            cycles++;
        end
        if (!allDone()) begin
            errCount++;
            $display("Timeout after %0d cycles: %0d of %0d results, %0d input credits back",
                     cycles, gotCnt, NumInst, creditsBack);
        end
        @(posedge Clk);
        #1;
        finalCredits: assert (creditsBack == NumInst)
            else begin
                errCount++;
                $display("FAILED at %0t: %0d of %0d input credits returned", $time,
                         creditsBack, NumInst);
            end
        $display("Summary: %0d errors, %0d of %0d results, %0d instructions sent",
                 errCount, gotCnt, NumInst, sentCnt);
        if (errCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tbClock.sv
// Testbench clock and reset source; 10 ns clock, reset held low for the first 16 cycles
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic Clk,
    output logic rstN
);

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    initial begin
        rstN = 1'b1;
        #1 rstN = 1'b0;                               // Clean falling edge for async reset
        repeat (16) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- src/sparcPipe.sv
// Top level of the credit-flow SPARC decode and execute pipeline; instantiate as the DUT
`timescale 1ns/1ps
`default_nettype none

module sparcPipe (
    input  wire logic                Clk,
    input  wire logic                rstN,
    input  wire logic                instValid,
    input  wire sparcPkg::instWord_t instIn,
    input  wire sparcPkg::dataWord_t operandA,
    input  wire sparcPkg::dataWord_t operandB,
    input  wire logic                resCredit,
    output logic                     instCredit,
    output logic                     resValid,
    output sparcPkg::result_t        resOut
);

    sparcPkg::issueSlot_t   slotIn;
    sparcPkg::issueSlot_t   head;
    sparcPkg::decodedInst_t decoded;
    logic                   headValid;
    logic                   pop;
    logic                   decValid;
    logic                   execTake;

    assign slotIn = '{inst: instIn, operandA: operandA, operandB: operandB};

    instQueue u_queue (
        .Clk, .rstN, .instValid, .slotIn, .pop,
        .headValid, .head, .instCredit
    );

    decodeStage u_decode (
        .Clk, .rstN, .headValid, .head, .execTake,
        .pop, .decValid, .decoded
    );

    executeStage u_execute (
        .Clk, .rstN, .decValid, .decoded, .resCredit,
        .execTake, .resValid, .resOut
    );

endmodule

`default_nettype wire

//--- src/executeStage.sv
// Execute stage: ALU, condition-code register, output credits and the EX/MEM result register
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire logic                   Clk,
    input  wire logic                   rstN,
    input  wire logic                   decValid,
    input  wire sparcPkg::decodedInst_t decoded,
    input  wire logic                   resCredit,
    output logic                        execTake,
    output logic                        resValid,
    output sparcPkg::result_t           resOut
);

    sparcPkg::creditCnt_t creditCnt;
    sparcPkg::iccFlags_t  iccReg;
    sparcPkg::iccFlags_t  aluFlags;
    sparcPkg::iccFlags_t  iccNext;
    sparcPkg::dataWord_t  aluY;
    logic                 hasCredit;
    logic                 take;

    sparcAlu u_alu (
        .a       (decoded.operandA),
        .b       (decoded.operandB),
        .op      (decoded.aluOp),
        .carryIn (iccReg.c),                          // Stored carry for addx and subx
        .y       (aluY),
        .flags   (aluFlags)
    );

    assign hasCredit = (creditCnt != '0);
    assign execTake  = hasCredit || !decValid;
    assign take      = decValid && hasCredit;
    assign iccNext   = decoded.setsCc ? aluFlags : iccReg;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            creditCnt <= sparcPkg::OutCredits;
            iccReg    <= '0;
            resValid  <= 1'b0;
        end else begin
            creditCnt <= creditCnt - sparcPkg::creditCnt_t'(take)
                         + sparcPkg::creditCnt_t'(resCredit);
            if (take) iccReg <= iccNext;
            resValid <= take;
        end
    end

    always_ff @(posedge Clk) begin
        if (take) begin
            resOut.data    <= aluY;
            resOut.icc     <= iccNext;
            resOut.memCtrl <= decoded.memCtrl;        // Passed on for the memory stage
        end
    end

endmodule

`default_nettype wire

//--- src/decodeStage.sv
// SPARC control unit decoding op/op3 into ALU and memory control, with the ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire logic                   Clk,
    input  wire logic                   rstN,
    input  wire logic                   headValid,
    input  wire sparcPkg::issueSlot_t   head,
    input  wire logic                   execTake,
    output logic                        pop,
    output logic                        decValid,
    output sparcPkg::decodedInst_t      decoded
);

    logic [1:0]             op;
    logic [5:0]             op3;
    logic                   arithHit;
    sparcPkg::aluOp_t       arithOp;
    sparcPkg::decodedInst_t nextDec;
    logic                   load;

    assign op  = head.inst[31:30];
    assign op3 = head.inst[24:19];

    // Arithmetic and logical group, low op3 nibble; op3[4] marks the cc variant
    always_comb begin
        arithHit = 1'b1;
        case (op3[3:0])
            4'b0000: arithOp = sparcPkg::AluAdd;
            4'b1000: arithOp = sparcPkg::AluAddx;
            4'b0100: arithOp = sparcPkg::AluSub;
            4'b1100: arithOp = sparcPkg::AluSubx;
            4'b0001: arithOp = sparcPkg::AluAnd;
            4'b0101: arithOp = sparcPkg::AluAndn;
            4'b0010: arithOp = sparcPkg::AluOr;
            4'b0110: arithOp = sparcPkg::AluOrn;
            4'b0011: arithOp = sparcPkg::AluXor;
            4'b0111: arithOp = sparcPkg::AluXnor;
            default: begin
                arithOp  = sparcPkg::AluAdd;
                arithHit = 1'b0;
            end
        endcase
    end

    always_comb begin
        nextDec.aluOp    = sparcPkg::AluAdd;          // Fallback for anything unsupported
        nextDec.setsCc   = 1'b0;
        nextDec.memCtrl  = '0;
        nextDec.operandA = head.operandA;
        nextDec.operandB = head.operandB;
        case (op)
            sparcPkg::OpArith: begin
                if (!op3[5] && arithHit) begin
                    nextDec.aluOp  = arithOp;
                    nextDec.setsCc = op3[4];
                end else begin
                    case (op3)
                        6'b100101: nextDec.aluOp = sparcPkg::AluSll;
                        6'b100110: nextDec.aluOp = sparcPkg::AluSrl;
                        6'b100111: nextDec.aluOp = sparcPkg::AluSra;
                        default:   nextDec.aluOp = sparcPkg::AluAdd;
                    endcase
                end
            end
            // Loads and stores only compute the address with an add
            sparcPkg::OpMem: begin
                case (op3)
                    6'b001001: nextDec.memCtrl = '{1'b1, 1'b0, sparcPkg::SizeByte, 1'b1}; // ldsb
                    6'b001010: nextDec.memCtrl = '{1'b1, 1'b0, sparcPkg::SizeHalf, 1'b1}; // ldsh
                    6'b000000: nextDec.memCtrl = '{1'b1, 1'b0, sparcPkg::SizeWord, 1'b0}; // ld
                    6'b000001: nextDec.memCtrl = '{1'b1, 1'b0, sparcPkg::SizeByte, 1'b0}; // ldub
                    6'b000010: nextDec.memCtrl = '{1'b1, 1'b0, sparcPkg::SizeHalf, 1'b0}; // lduh
                    6'b000011: nextDec.memCtrl = '{1'b1, 1'b0, sparcPkg::SizeWord, 1'b0}; // ldd
                    6'b001101: nextDec.memCtrl = '{1'b1, 1'b0, sparcPkg::SizeByte, 1'b0}; // ldstub
                    6'b001111: nextDec.memCtrl = '{1'b1, 1'b0, sparcPkg::SizeWord, 1'b0}; // swap
                    6'b000101: nextDec.memCtrl = '{1'b1, 1'b1, sparcPkg::SizeByte, 1'b0}; // stb
                    6'b000110: nextDec.memCtrl = '{1'b1, 1'b1, sparcPkg::SizeHalf, 1'b0}; // sth
                    6'b000100: nextDec.memCtrl = '{1'b1, 1'b1, sparcPkg::SizeWord, 1'b0}; // st
                    6'b000111: nextDec.memCtrl = '{1'b1, 1'b1, sparcPkg::SizeWord, 1'b0}; // std
                    default:   nextDec.memCtrl = '0;
                endcase
            end
            2'b00: begin
                if (head.inst[24:22] == sparcPkg::OpSethi2) begin
                    nextDec.aluOp = sparcPkg::AluPassB;
                end
            end
            default: nextDec.aluOp = sparcPkg::AluAdd;   // Call
        endcase
    end

    // ID/EX loads when empty or when execute accepts the current entry
    assign load = !decValid || execTake;
    assign pop  = headValid && load;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (load) begin
            decValid <= headValid;                    // No head leaves a bubble
        end
    end

    always_ff @(posedge Clk) begin
        if (pop) begin
            decoded <= nextDec;
        end
    end

endmodule

`default_nettype wire

//--- src/instQueue.sv
// Two-entry instruction buffer in front of decode; each popped entry returns one input credit
`timescale 1ns/1ps
`default_nettype none

module instQueue (
    input  wire logic                 Clk,
    input  wire logic                 rstN,
    input  wire logic                 instValid,
    input  wire sparcPkg::issueSlot_t slotIn,
    input  wire logic                 pop,
    output logic                      headValid,
    output sparcPkg::issueSlot_t      head,
    output logic                      instCredit
);

    sparcPkg::issueSlot_t slots [sparcPkg::QueueDepth];
    logic                 wrPtr;
    logic                 rdPtr;
    logic [1:0]           count;                      // Occupied entries, 0 to 2

    // Upstream credits guarantee no write while full
    always_ff @(posedge Clk) begin
        if (instValid) begin
            slots[wrPtr] <= slotIn;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr      <= 1'b0;
            rdPtr      <= 1'b0;
            count      <= 2'd0;
            instCredit <= 1'b0;
        end else begin
            if (instValid) wrPtr <= ~wrPtr;
            if (pop) rdPtr <= ~rdPtr;
            count      <= count + {1'b0, instValid} - {1'b0, pop};
            instCredit <= pop;                        // Credit goes back the cycle after a pop
        end
    end

    assign headValid = (count != 2'd0);
    assign head      = slots[rdPtr];

endmodule

`default_nettype wire

//--- src/sparcAlu.sv
// Combinational 32-bit SPARC ALU producing the result and N, Z, V, C flags
`timescale 1ns/1ps
`default_nettype none

module sparcAlu (
    input  wire sparcPkg::dataWord_t a,
    input  wire sparcPkg::dataWord_t b,
    input  wire sparcPkg::aluOp_t    op,
    input  wire logic                carryIn,
    output sparcPkg::dataWord_t      y,
    output sparcPkg::iccFlags_t      flags
);

    logic [32:0] wide;                                // Result with carry or borrow on top
    logic [4:0]  shamt;

    assign shamt = b[4:0];

    always_comb begin
        wide    = '0;
        flags.v = 1'b0;
        case (op)
            sparcPkg::AluAdd:   wide = {1'b0, a} + {1'b0, b};
            sparcPkg::AluAddx:  wide = {1'b0, a} + {1'b0, b} + {32'd0, carryIn};
            sparcPkg::AluSub:   wide = {1'b0, a} - {1'b0, b};
            sparcPkg::AluSubx:  wide = {1'b0, a} - {1'b0, b} - {32'd0, carryIn};
            sparcPkg::AluAnd:   wide = {1'b0, a & b};
            sparcPkg::AluOr:    wide = {1'b0, a | b};
            sparcPkg::AluXor:   wide = {1'b0, a ^ b};
            sparcPkg::AluXnor:  wide = {1'b0, ~(a ^ b)};
            sparcPkg::AluAndn:  wide = {1'b0, a & ~b};
            sparcPkg::AluOrn:   wide = {1'b0, a | ~b};
            sparcPkg::AluSll:   wide = {1'b0, a << shamt};
            sparcPkg::AluSrl:   wide = {1'b0, a >> shamt};
            sparcPkg::AluSra:   wide = {1'b0, $signed(a) >>> shamt};
            sparcPkg::AluPassB: wide = {1'b0, b};
            default:            wide = '0;
        endcase
        y       = wide[31:0];
        flags.n = wide[31];
        flags.z = (wide[31:0] == 32'd0);
        flags.c = 1'b0;
        if (op == sparcPkg::AluAdd || op == sparcPkg::AluAddx) begin
            flags.c = wide[32];
            flags.v = (a[31] == b[31]) && (a[31] != wide[31]);   // Same-sign inputs, sign flipped
        end else if (op == sparcPkg::AluSub || op == sparcPkg::AluSubx) begin
            flags.c = wide[32];                       // Borrow
            flags.v = (a[31] != b[31]) && (a[31] != wide[31]);
        end
    end

endmodule

`default_nettype wire

//--- src/sparcPkg.sv
// Shared widths, SPARC opcode constants, ALU codes and pipeline structs for the sparcPipe core
`default_nettype none

package sparcPkg;

    typedef logic [31:0] instWord_t;                  // Raw SPARC instruction
    typedef logic [31:0] dataWord_t;                  // Operand or ALU result
    typedef logic [3:0]  aluOp_t;                     // ALU operation select
    typedef logic [1:0]  memSize_t;                   // Data access size
    typedef logic [2:0]  creditCnt_t;                 // Output credit counter

    // ALU operation codes
    localparam aluOp_t AluAdd   = 4'b0000;
    localparam aluOp_t AluAddx  = 4'b0001;            // A + B + stored carry
    localparam aluOp_t AluSub   = 4'b0010;
    localparam aluOp_t AluSubx  = 4'b0011;            // A - B - stored carry
    localparam aluOp_t AluAnd   = 4'b0100;
    localparam aluOp_t AluOr    = 4'b0101;
    localparam aluOp_t AluXor   = 4'b0110;
    localparam aluOp_t AluXnor  = 4'b0111;
    localparam aluOp_t AluAndn  = 4'b1000;
    localparam aluOp_t AluOrn   = 4'b1001;
    localparam aluOp_t AluSll   = 4'b1010;
    localparam aluOp_t AluSrl   = 4'b1011;
    localparam aluOp_t AluSra   = 4'b1100;
    localparam aluOp_t AluPassB = 4'b1110;            // Sethi, B already holds imm22 << 10

    // Instruction format fields
    localparam logic [1:0] OpArith  = 2'b10;
    localparam logic [1:0] OpMem    = 2'b11;
    localparam logic [2:0] OpSethi2 = 3'b100;         // op2 field under op = 00

    localparam memSize_t SizeByte = 2'd0;
    localparam memSize_t SizeHalf = 2'd1;
    localparam memSize_t SizeWord = 2'd2;

    localparam int         QueueDepth = 2;            // Input credits held upstream after reset
    localparam creditCnt_t OutCredits = 3'd4;         // Output credits held by the core

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } iccFlags_t;

    typedef struct packed {
        logic     isMem;
        logic     isStore;
        memSize_t size;
        logic     signExt;                            // Signed byte or halfword load
    } memCtrl_t;

    typedef struct packed {
        instWord_t inst;
        dataWord_t operandA;
        dataWord_t operandB;
    } issueSlot_t;

    typedef struct packed {
        aluOp_t    aluOp;
        logic      setsCc;
        memCtrl_t  memCtrl;
        dataWord_t operandA;
        dataWord_t operandB;
    } decodedInst_t;

    typedef struct packed {
        dataWord_t data;
        iccFlags_t icc;                               // Condition codes after this instruction
        memCtrl_t  memCtrl;
    } result_t;

endpackage

`default_nettype wire
